// ==== src.f ====
common/bus_pkg.sv
hdl/clint.sv
arbiter/bus_arbiter.sv
hdl/bus_subsystem.sv
bench/clock_gen.sv
bench/axi_mem_model.sv
bench/tb_bus_subsystem.sv

// ==== bench/tb_bus_subsystem.sv ====
`timescale 1ns/100ps

module tb_bus_subsystem;
  import bus_pkg::*;

  localparam addr_t MTIME_ADDR = 32'h0200_0048;
  localparam int    N_ROWS     = 7;
  localparam int    RST_CYCLES = 16;
  localparam size_t LSU_ARSIZE = 3'b001;  // Halfword, unlike the ifu's size.

  typedef enum {IFU_RD, TIMER_RD, LSU_WR, LSU_RD, BOTH_RD, STALL_RD} kind_t;
  typedef struct {
    kind_t kind;
    bit    lsu;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    data_t exp;
  } row_t;

  logic clock, arst_n;
  addr_t ifu_araddr, lsu_araddr, lsu_awaddr;
  logic ifu_arvalid, ifu_rready, lsu_arvalid, lsu_rready;
  logic lsu_awvalid, lsu_wvalid, lsu_bready;
  size_t lsu_arsize, lsu_awsize;
  data_t lsu_wdata;
  strb_t lsu_wstrb;
  logic ifu_arready, ifu_rvalid, lsu_arready, lsu_rvalid;
  logic lsu_awready, lsu_wready, lsu_bvalid;
  data_t ifu_rdata, lsu_rdata;
  resp_t ifu_rresp, lsu_rresp, lsu_bresp;
  logic io_awready, io_awvalid, io_wready, io_wvalid, io_wlast, io_bready, io_bvalid;
  logic io_arready, io_arvalid, io_rready, io_rvalid, io_rlast;
  axi_id_t io_awid, io_bid, io_arid, io_rid;
  addr_t io_awaddr, io_araddr;
  len_t io_awlen, io_arlen;
  size_t io_awsize, io_arsize, last_arsize;
  burst_t io_awburst, io_arburst;
  data_t io_wdata, io_rdata;
  strb_t io_wstrb;
  resp_t io_bresp, io_rresp;
  int rd_count;
  axi_id_t last_arid;

  int errors = 0;
  longint cyc;
  row_t rows [N_ROWS];

  clock_gen #(.PERIOD(20)) i_clock_gen (.clock(clock));

  bus_subsystem #(.MTIME_ADDR(MTIME_ADDR)) i_dut (
    .clock(clock), .arst_n(arst_n),
    .ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
    .ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp), .ifu_rvalid(ifu_rvalid),
    .ifu_rready(ifu_rready),
    .lsu_araddr(lsu_araddr), .lsu_arsize(lsu_arsize), .lsu_arvalid(lsu_arvalid),
    .lsu_arready(lsu_arready), .lsu_rdata(lsu_rdata), .lsu_rresp(lsu_rresp),
    .lsu_rvalid(lsu_rvalid), .lsu_rready(lsu_rready),
    .lsu_awaddr(lsu_awaddr), .lsu_awsize(lsu_awsize), .lsu_awvalid(lsu_awvalid),
    .lsu_awready(lsu_awready), .lsu_wdata(lsu_wdata), .lsu_wstrb(lsu_wstrb),
    .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready), .lsu_bresp(lsu_bresp),
    .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
    .io_master_awready(io_awready), .io_master_awvalid(io_awvalid),
    .io_master_awid(io_awid), .io_master_awaddr(io_awaddr), .io_master_awlen(io_awlen),
    .io_master_awsize(io_awsize), .io_master_awburst(io_awburst),
    .io_master_wready(io_wready), .io_master_wvalid(io_wvalid),
    .io_master_wdata(io_wdata), .io_master_wstrb(io_wstrb), .io_master_wlast(io_wlast),
    .io_master_bready(io_bready), .io_master_bvalid(io_bvalid), .io_master_bid(io_bid),
    .io_master_bresp(io_bresp), .io_master_arready(io_arready),
    .io_master_arvalid(io_arvalid), .io_master_arid(io_arid),
    .io_master_araddr(io_araddr), .io_master_arlen(io_arlen),
    .io_master_arsize(io_arsize), .io_master_arburst(io_arburst),
    .io_master_rready(io_rready), .io_master_rvalid(io_rvalid), .io_master_rid(io_rid),
    .io_master_rdata(io_rdata), .io_master_rresp(io_rresp), .io_master_rlast(io_rlast)
  );

  axi_mem_model i_mem (
    .clock(clock), .arst_n(arst_n),
    .awready(io_awready), .awvalid(io_awvalid), .awaddr(io_awaddr),
    .wready(io_wready), .wvalid(io_wvalid), .wdata(io_wdata), .wstrb(io_wstrb),
    .bready(io_bready), .bvalid(io_bvalid), .bid(io_bid), .bresp(io_bresp),
    .arready(io_arready), .arvalid(io_arvalid), .arid(io_arid), .araddr(io_araddr),
    .arsize(io_arsize), .rready(io_rready), .rvalid(io_rvalid), .rid(io_rid),
    .rdata(io_rdata), .rresp(io_rresp), .rlast(io_rlast),
    .rd_count(rd_count), .last_arid(last_arid), .last_arsize(last_arsize)
  );

  // Cycles since reset release, equal to mtime between edges.
  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  function automatic data_t fill_word(addr_t addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  function automatic data_t timer_word(addr_t addr, longint count);
    return addr[2] ? count[63:32] : count[31:0];
  endfunction

  task automatic master_read(input bit lsu, input addr_t addr, input int hold,
                             output data_t data, output resp_t resp,
                             output longint ar_cyc, output time r_time);
    data_t first;
    @(posedge clock);
    #2;
    if (lsu) begin
      lsu_araddr = addr;
      lsu_arvalid = 1'b1;
    end else begin
      ifu_araddr = addr;
      ifu_arvalid = 1'b1;
    end
    do @(negedge clock); while (!(lsu ? lsu_arready : ifu_arready));
    ar_cyc = cyc;  // Handshake at the coming edge.
    if (io_arvalid && io_arready) begin
      check("io_master_arlen", 0, io_arlen);
      check("io_master_arburst", BURST_INCR, io_arburst);
    end
    @(posedge clock);
    #2;
    if (lsu) begin
      lsu_arvalid = 1'b0;
      lsu_rready = (hold == 0);
    end else begin
      ifu_arvalid = 1'b0;
      ifu_rready = 1'b1;
    end
    do @(negedge clock); while (!(lsu ? lsu_rvalid : ifu_rvalid));
    if (hold > 0) begin
      first = lsu_rdata;
      repeat (hold) begin
        @(negedge clock);
        check("lsu_rvalid", 1, lsu_rvalid);
        check("lsu_rdata", first, lsu_rdata);
      end
      @(posedge clock);
      #2 lsu_rready = 1'b1;
      @(negedge clock);
      check("lsu_rvalid", 1, lsu_rvalid);
    end
    data = lsu ? lsu_rdata : ifu_rdata;
    resp = lsu ? lsu_rresp : ifu_rresp;
    r_time = $time;
    @(posedge clock);
    #2;
    if (lsu) begin
      lsu_rready = 1'b0;
    end else begin
      ifu_rready = 1'b0;
    end
  endtask

  task automatic lsu_write(input addr_t addr, input data_t data, input strb_t strb,
                           output resp_t resp);
    @(posedge clock);
    #2;
    lsu_awaddr = addr;
    lsu_awsize = SIZE_WORD;
    lsu_awvalid = 1'b1;
    lsu_wdata = data;
    lsu_wstrb = strb;
    lsu_wvalid = 1'b1;
    lsu_bready = 1'b1;
    do @(negedge clock); while (!(lsu_awready && lsu_wready));
    check("io_master_awid", ID_LSU, io_awid);
    check("io_master_awlen", 0, io_awlen);
    check("io_master_awsize", SIZE_WORD, io_awsize);
    check("io_master_awburst", BURST_INCR, io_awburst);
    check("io_master_wlast", 1, io_wlast);
    @(posedge clock);
    #2;
    lsu_awvalid = 1'b0;
    lsu_wvalid = 1'b0;
    do @(negedge clock); while (!lsu_bvalid);
    resp = lsu_bresp;
    @(posedge clock);
    #2 lsu_bready = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    data_t d0, d1;
    resp_t r0, r1;
    longint c0, c1;
    time t0, t1;
    int n;
    n = rd_count;
    case (r.kind)
      IFU_RD, LSU_RD: begin
        master_read(r.lsu, r.addr, 0, d0, r0, c0, t0);
        check("rdata", r.exp, d0);
        check("rresp", RESP_OKAY, r0);
        check("read count", n + 1, rd_count);
        check("arid", r.lsu ? ID_LSU : ID_IFU, last_arid);
        check("arsize", r.lsu ? LSU_ARSIZE : SIZE_WORD, last_arsize);
      end
      TIMER_RD: begin
        master_read(1'b1, r.addr, 0, d0, r0, c0, t0);
        check("lsu_rdata", timer_word(r.addr, c0), d0);
        check("lsu_rresp", RESP_OKAY, r0);
        check("read count", n, rd_count);
      end
      LSU_WR: begin
        lsu_write(r.addr, r.wdata, r.strb, r0);
        check("lsu_bresp", RESP_OKAY, r0);
      end
      BOTH_RD: begin
        fork
          master_read(1'b0, r.addr, 0, d0, r0, c0, t0);
          master_read(1'b1, r.addr + 4, 0, d1, r1, c1, t1);
        join
        check("ifu_rdata", r.exp, d0);
        check("lsu_rdata", fill_word(r.addr + 4), d1);
        if (t0 >= t1) begin
          errors++;
          $display("Ordering error at %0t ns: lsu data came before ifu data", $time);
        end
      end
      STALL_RD: begin
        fork
          master_read(1'b1, MTIME_ADDR, 6, d1, r1, c1, t1);
          begin
            repeat (3) @(posedge clock);
            master_read(1'b0, r.addr, 0, d0, r0, c0, t0);
          end
        join
        check("lsu_rdata", timer_word(MTIME_ADDR, c1), d1);
        check("ifu_rdata", r.exp, d0);
        if (t0 <= t1) begin
          errors++;
          $display("Ordering error at %0t ns: ifu read ended during the stall", $time);
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    #((N_ROWS * 200 + RST_CYCLES + 4) * 20);
    $display("Watchdog timeout at %0t ns: the bus stopped responding", $time);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rows[0] = '{IFU_RD,   1'b0, 32'h8000_0100, '0, '0, 32'hda5a_0100};
    rows[1] = '{TIMER_RD, 1'b1, MTIME_ADDR,     '0, '0, '0};
    rows[2] = '{TIMER_RD, 1'b1, MTIME_ADDR + 4, '0, '0, '0};
    rows[3] = '{LSU_WR,   1'b1, 32'h8000_0010, 32'haabb_ccdd, 4'b0101, '0};
    rows[4] = '{LSU_RD,   1'b1, 32'h8000_0010, '0, '0, 32'hdabb_00dd};  // Merged bytes.
    rows[5] = '{BOTH_RD,  1'b0, 32'h8000_0200, '0, '0, 32'hda5a_0200};
    rows[6] = '{STALL_RD, 1'b0, 32'h8000_0300, '0, '0, 32'hda5a_0300};
    arst_n = 1'b0;
    ifu_araddr = '0;
    ifu_arvalid = 1'b0;
    ifu_rready = 1'b0;
    lsu_araddr = '0;
    lsu_arsize = LSU_ARSIZE;
    lsu_arvalid = 1'b0;
    lsu_rready = 1'b0;
    lsu_awaddr = '0;
    lsu_awsize = SIZE_WORD;
    lsu_awvalid = 1'b0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    lsu_wvalid = 1'b0;
    lsu_bready = 1'b0;
    repeat (RST_CYCLES) begin
      @(negedge clock);
      check("reset ready/valid", 0,
            {ifu_arready, lsu_arready, ifu_rvalid, lsu_rvalid, io_arvalid});
    end
    @(posedge clock);
    #2 arst_n = 1'b1;
    @(negedge clock);
    check("ready/valid after reset", 0,
          {ifu_arready, lsu_arready, ifu_rvalid, lsu_rvalid, io_arvalid});
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model
  import bus_pkg::*;
(
  input  logic    clock,
  input  logic    arst_n,
  output logic    awready,
  input  logic    awvalid,
  input  addr_t   awaddr,
  output logic    wready,
  input  logic    wvalid,
  input  data_t   wdata,
  input  strb_t   wstrb,
  input  logic    bready,
  output logic    bvalid,
  output axi_id_t bid,
  output resp_t   bresp,
  output logic    arready,
  input  logic    arvalid,
  input  axi_id_t arid,
  input  addr_t   araddr,
  input  size_t   arsize,
  input  logic    rready,
  output logic    rvalid,
  output axi_id_t rid,
  output data_t   rdata,
  output resp_t   rresp,
  output logic    rlast,
  output int      rd_count,
  output axi_id_t last_arid,
  output size_t   last_arsize
);

  data_t mem [logic [29:0]];

  function automatic data_t read_word(addr_t addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;  // Fill pattern.
  endfunction

  assign rlast = rvalid;

  initial begin
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bid = ID_LSU;
    bresp = RESP_OKAY;
    arready = 1'b0;
    rvalid = 1'b0;
    rid = '0;
    rdata = '0;
    rresp = RESP_OKAY;
    rd_count = 0;
    last_arid = '0;
    last_arsize = '0;
    void'($urandom(32'h9d9a_a26e));
    fork
      begin : rd_port
        int unsigned rd_delay;
        addr_t       rd_addr;
        forever begin
          @(negedge clock);
          if (arst_n && arvalid) begin
            rd_delay = $urandom_range(3, 0);
            repeat (rd_delay + 1) @(posedge clock);
            #2 arready = 1'b1;  // Handshake at the next edge.
            @(negedge clock);
            rd_addr = araddr;
            last_arid = arid;
            last_arsize = arsize;
            rd_count = rd_count + 1;
            @(posedge clock);
            #2;
            arready = 1'b0;
            rid = last_arid;
            rdata = read_word(rd_addr);
            rvalid = 1'b1;
            do @(negedge clock); while (!rready);
            @(posedge clock);
            #2 rvalid = 1'b0;
          end
        end
      end
      begin : wr_port
        int unsigned wr_delay;
        data_t       word;
        addr_t       wr_addr;
        forever begin
          @(negedge clock);
          if (arst_n && awvalid && wvalid) begin
            wr_delay = $urandom_range(3, 0);
            repeat (wr_delay + 1) @(posedge clock);
            #2;
            awready = 1'b1;
            wready = 1'b1;
            @(negedge clock);
            wr_addr = awaddr;
            word = read_word(wr_addr);
            for (int i = 0; i < 4; i++) begin
              if (wstrb[i]) word[8*i +: 8] = wdata[8*i +: 8];
            end
            mem[wr_addr[31:2]] = word;
            @(posedge clock);
            #2;
            awready = 1'b0;
            wready = 1'b0;
            bvalid = 1'b1;
            do @(negedge clock); while (!bready);
            @(posedge clock);
            #2 bvalid = 1'b0;
          end
        end
      end
    join
  end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

endmodule

// ==== hdl/bus_subsystem.sv ====
`timescale 1ns/100ps

module bus_subsystem
  import bus_pkg::*;
#(
  parameter addr_t MTIME_ADDR = 32'h0200_0048  // Low mtime word.
) (
  input  logic    clock,
  input  logic    arst_n,

  input  addr_t   ifu_araddr,
  input  logic    ifu_arvalid,
  output logic    ifu_arready,
  output data_t   ifu_rdata,
  output resp_t   ifu_rresp,
  output logic    ifu_rvalid,
  input  logic    ifu_rready,

  input  addr_t   lsu_araddr,
  input  size_t   lsu_arsize,
  input  logic    lsu_arvalid,
  output logic    lsu_arready,
  output data_t   lsu_rdata,
  output resp_t   lsu_rresp,
  output logic    lsu_rvalid,
  input  logic    lsu_rready,

  input  addr_t   lsu_awaddr,
  input  size_t   lsu_awsize,
  input  logic    lsu_awvalid,
  output logic    lsu_awready,
  input  data_t   lsu_wdata,
  input  strb_t   lsu_wstrb,
  input  logic    lsu_wvalid,
  output logic    lsu_wready,
  output resp_t   lsu_bresp,
  output logic    lsu_bvalid,
  input  logic    lsu_bready,

  input  logic    io_master_awready,
  output logic    io_master_awvalid,
  output axi_id_t io_master_awid,
  output addr_t   io_master_awaddr,
  output len_t    io_master_awlen,
  output size_t   io_master_awsize,
  output burst_t  io_master_awburst,
  input  logic    io_master_wready,
  output logic    io_master_wvalid,
  output data_t   io_master_wdata,
  output strb_t   io_master_wstrb,
  output logic    io_master_wlast,
  output logic    io_master_bready,
  input  logic    io_master_bvalid,
  input  axi_id_t io_master_bid,
  input  resp_t   io_master_bresp,
  input  logic    io_master_arready,
  output logic    io_master_arvalid,
  output axi_id_t io_master_arid,
  output addr_t   io_master_araddr,
  output len_t    io_master_arlen,
  output size_t   io_master_arsize,
  output burst_t  io_master_arburst,
  output logic    io_master_rready,
  input  logic    io_master_rvalid,
  input  axi_id_t io_master_rid,
  input  data_t   io_master_rdata,
  input  resp_t   io_master_rresp,
  input  logic    io_master_rlast
);

  bus_arbiter #(
    .MTIME_ADDR (MTIME_ADDR)
  ) i_bus_arbiter (
    .clock             (clock),
    .arst_n            (arst_n),
    .ifu_araddr        (ifu_araddr),
    .ifu_arvalid       (ifu_arvalid),
    .ifu_arready       (ifu_arready),
    .ifu_rdata         (ifu_rdata),
    .ifu_rresp         (ifu_rresp),
    .ifu_rvalid        (ifu_rvalid),
    .ifu_rready        (ifu_rready),
    .lsu_araddr        (lsu_araddr),
    .lsu_arsize        (lsu_arsize),
    .lsu_arvalid       (lsu_arvalid),
    .lsu_arready       (lsu_arready),
    .lsu_rdata         (lsu_rdata),
    .lsu_rresp         (lsu_rresp),
    .lsu_rvalid        (lsu_rvalid),
    .lsu_rready        (lsu_rready),
    .lsu_awaddr        (lsu_awaddr),
    .lsu_awsize        (lsu_awsize),
    .lsu_awvalid       (lsu_awvalid),
    .lsu_awready       (lsu_awready),
    .lsu_wdata         (lsu_wdata),
    .lsu_wstrb         (lsu_wstrb),
    .lsu_wvalid        (lsu_wvalid),
    .lsu_wready        (lsu_wready),
    .lsu_bresp         (lsu_bresp),
    .lsu_bvalid        (lsu_bvalid),
    .lsu_bready        (lsu_bready),
    .io_master_awready (io_master_awready),
    .io_master_awvalid (io_master_awvalid),
    .io_master_awid    (io_master_awid),
    .io_master_awaddr  (io_master_awaddr),
    .io_master_awlen   (io_master_awlen),
    .io_master_awsize  (io_master_awsize),
    .io_master_awburst (io_master_awburst),
    .io_master_wready  (io_master_wready),
    .io_master_wvalid  (io_master_wvalid),
    .io_master_wdata   (io_master_wdata),
    .io_master_wstrb   (io_master_wstrb),
    .io_master_wlast   (io_master_wlast),
    .io_master_bready  (io_master_bready),
    .io_master_bvalid  (io_master_bvalid),
    .io_master_bid     (io_master_bid),
    .io_master_bresp   (io_master_bresp),
    .io_master_arready (io_master_arready),
    .io_master_arvalid (io_master_arvalid),
    .io_master_arid    (io_master_arid),
    .io_master_araddr  (io_master_araddr),
    .io_master_arlen   (io_master_arlen),
    .io_master_arsize  (io_master_arsize),
    .io_master_arburst (io_master_arburst),
    .io_master_rready  (io_master_rready),
    .io_master_rvalid  (io_master_rvalid),
    .io_master_rid     (io_master_rid),
    .io_master_rdata   (io_master_rdata),
    .io_master_rresp   (io_master_rresp),
    .io_master_rlast   (io_master_rlast)
  );

endmodule

// ==== arbiter/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter
  import bus_pkg::*;
#(
  parameter addr_t MTIME_ADDR = 32'h0200_0048
) (
  input  logic    clock,
  input  logic    arst_n,

  input  addr_t   ifu_araddr,
  input  logic    ifu_arvalid,
  output logic    ifu_arready,
  output data_t   ifu_rdata,
  output resp_t   ifu_rresp,
  output logic    ifu_rvalid,
  input  logic    ifu_rready,

  input  addr_t   lsu_araddr,
  input  size_t   lsu_arsize,
  input  logic    lsu_arvalid,
  output logic    lsu_arready,
  output data_t   lsu_rdata,
  output resp_t   lsu_rresp,
  output logic    lsu_rvalid,
  input  logic    lsu_rready,

  input  addr_t   lsu_awaddr,
  input  size_t   lsu_awsize,
  input  logic    lsu_awvalid,
  output logic    lsu_awready,
  input  data_t   lsu_wdata,
  input  strb_t   lsu_wstrb,
  input  logic    lsu_wvalid,
  output logic    lsu_wready,
  output resp_t   lsu_bresp,
  output logic    lsu_bvalid,
  input  logic    lsu_bready,

  input  logic    io_master_awready,
  output logic    io_master_awvalid,
  output axi_id_t io_master_awid,
  output addr_t   io_master_awaddr,
  output len_t    io_master_awlen,
  output size_t   io_master_awsize,
  output burst_t  io_master_awburst,
  input  logic    io_master_wready,
  output logic    io_master_wvalid,
  output data_t   io_master_wdata,
  output strb_t   io_master_wstrb,
  output logic    io_master_wlast,
  output logic    io_master_bready,
  input  logic    io_master_bvalid,
  input  axi_id_t io_master_bid,
  input  resp_t   io_master_bresp,
  input  logic    io_master_arready,
  output logic    io_master_arvalid,
  output axi_id_t io_master_arid,
  output addr_t   io_master_araddr,
  output len_t    io_master_arlen,
  output size_t   io_master_arsize,
  output burst_t  io_master_arburst,
  output logic    io_master_rready,
  input  logic    io_master_rvalid,
  input  axi_id_t io_master_rid,
  input  data_t   io_master_rdata,
  input  resp_t   io_master_rresp,
  input  logic    io_master_rlast
);

  localparam addr_t MTIME_HI_ADDR = MTIME_ADDR + 32'd4;

  rd_state_t state;
  logic      gnt_lsu;  // 0 ifu, 1 lsu.
  logic      ar_done;
  logic      lsu_is_clint;

  addr_t     gnt_araddr;
  logic      gnt_arvalid;
  logic      gnt_rready;
  logic      ar_fire;
  logic      r_fire;

  logic      tgt_arready;
  data_t     tgt_rdata;
  resp_t     tgt_rresp;
  logic      tgt_rvalid;

  logic      clint_arvalid;
  logic      clint_arready;
  logic      clint_rready;
  data_t     clint_rdata;
  resp_t     clint_rresp;
  logic      clint_rvalid;

  assign lsu_is_clint = (lsu_araddr == MTIME_ADDR) || (lsu_araddr == MTIME_HI_ADDR);

  assign gnt_araddr  = gnt_lsu ? lsu_araddr : ifu_araddr;
  assign gnt_arvalid = ~ar_done & (gnt_lsu ? lsu_arvalid : ifu_arvalid);
  assign gnt_rready  = gnt_lsu ? lsu_rready : ifu_rready;

  assign ar_fire = gnt_arvalid & tgt_arready;
  assign r_fire  = tgt_rvalid & gnt_rready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      gnt_lsu <= 1'b0;
      ar_done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (ifu_arvalid) begin  // Fetch wins.
            state   <= XFER_EXT;
            gnt_lsu <= 1'b0;
          end else if (lsu_arvalid) begin
            state   <= lsu_is_clint ? XFER_CLINT : XFER_EXT;
            gnt_lsu <= 1'b1;
          end
        end
        default: begin
          if (ar_fire) begin
            ar_done <= 1'b1;
          end
          if (r_fire) begin
            state   <= IDLE;
            ar_done <= 1'b0;
          end
        end
      endcase
    end
  end

  // Target of the current grant.
  always_comb begin
    tgt_arready = 1'b0;
    tgt_rvalid  = 1'b0;
    tgt_rdata   = io_master_rdata;
    tgt_rresp   = io_master_rresp;
    case (state)
      XFER_EXT: begin
        tgt_arready = io_master_arready;
        tgt_rvalid  = io_master_rvalid;
      end
      XFER_CLINT: begin
        tgt_arready = clint_arready;
        tgt_rvalid  = clint_rvalid;
        tgt_rdata   = clint_rdata;
        tgt_rresp   = clint_rresp;
      end
      default: ;
    endcase
  end

  assign ifu_arready = ~gnt_lsu & ~ar_done & tgt_arready;
  assign ifu_rvalid  = ~gnt_lsu & tgt_rvalid;
  assign ifu_rdata   = tgt_rdata;
  assign ifu_rresp   = tgt_rresp;

  assign lsu_arready = gnt_lsu & ~ar_done & tgt_arready;
  assign lsu_rvalid  = gnt_lsu & tgt_rvalid;
  assign lsu_rdata   = tgt_rdata;
  assign lsu_rresp   = tgt_rresp;

  assign io_master_arvalid = (state == XFER_EXT) & gnt_arvalid;
  assign io_master_araddr  = gnt_araddr;
  assign io_master_arid    = gnt_lsu ? ID_LSU : ID_IFU;
  assign io_master_arsize  = gnt_lsu ? lsu_arsize : SIZE_WORD;
  assign io_master_arlen   = '0;  // Single beat.
  assign io_master_arburst = BURST_INCR;
  assign io_master_rready  = (state == XFER_EXT) & gnt_rready;

  // Writes always go out.
  assign io_master_awvalid = lsu_awvalid;
  assign io_master_awid    = ID_LSU;
  assign io_master_awaddr  = lsu_awaddr;
  assign io_master_awlen   = '0;
  assign io_master_awsize  = lsu_awsize;
  assign io_master_awburst = BURST_INCR;
  assign io_master_wvalid  = lsu_wvalid;
  assign io_master_wdata   = lsu_wdata;
  assign io_master_wstrb   = lsu_wstrb;
  assign io_master_wlast   = lsu_wvalid;
  assign io_master_bready  = lsu_bready;
  assign lsu_awready       = io_master_awready;
  assign lsu_wready        = io_master_wready;
  assign lsu_bresp         = io_master_bresp;
  assign lsu_bvalid        = io_master_bvalid;

  assign clint_arvalid = (state == XFER_CLINT) & gnt_arvalid;
  assign clint_rready  = (state == XFER_CLINT) & gnt_rready;

  clint i_clint (
    .clock   (clock),
    .arst_n  (arst_n),
    .araddr  (gnt_araddr),
    .arvalid (clint_arvalid),
    .arready (clint_arready),
    .rready  (clint_rready),
    .rdata   (clint_rdata),
    .rresp   (clint_rresp),
    .rvalid  (clint_rvalid)
  );

endmodule

// ==== hdl/clint.sv ====
`timescale 1ns/100ps

module clint
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  arst_n,

  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,

  input  logic  rready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid
);

  logic [63:0] mtime;
  logic        ar_fire;
  data_t       mtime_sel;

  assign arready   = ~rvalid;  // One response slot.
  assign ar_fire   = arvalid & arready;
  assign rresp     = RESP_OKAY;
  assign mtime_sel = araddr[2] ? mtime[63:32] : mtime[31:0];

  // Free-running machine timer.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;  // Response taken.
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= mtime_sel;  // Snapshot at address handshake.
    end
  end

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [2:0]  size_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  len_t;
  typedef logic [1:0]  burst_t;

  localparam resp_t   RESP_OKAY  = 2'b00;
  localparam burst_t  BURST_INCR = 2'b01;
  localparam size_t   SIZE_WORD  = 3'b010;  // 4 bytes per beat.

  localparam axi_id_t ID_IFU = 4'd0;
  localparam axi_id_t ID_LSU = 4'd1;

  // Read grant state of the bus arbiter.
  typedef enum logic [1:0] {
    IDLE,
    XFER_EXT,
    XFER_CLINT
  } rd_state_t;

endpackage
